/* Bender.yml */
package:
  name: motion_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/motion_pkg.sv
      - hdl/drive_pkg.sv
      - hdl/move_intake.sv
      - hdl/move_buffer.sv
      - hdl/step_sequencer.sv
      - hdl/quad_decoder.sv
      - hdl/motion_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/motion_core_tb.sv

/* bench/motion_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module motion_core_tb import motion_pkg::*; import drive_pkg::*; ();

  localparam int MAX_REC   = 64;
  localparam int MAX_MOVES = 32;
  localparam int MIN_P     = `MOTION_MIN_PERIOD;

  // Record opcode in the top nibble of each golden line
  localparam logic [3:0] OP_END   = 4'h0;
  localparam logic [3:0] OP_MOVE  = 4'h1;
  localparam logic [3:0] OP_HALT  = 4'h2;
  localparam logic [3:0] OP_IDLE  = 4'h3; // Wait for move_done and check position
  localparam logic [3:0] OP_BUSY  = 4'h4;
  localparam logic [3:0] OP_READY = 4'h5;
  localparam logic [3:0] OP_ENC   = 4'h6;
  localparam logic [3:0] OP_COUNT = 4'h7;
  localparam logic [3:0] OP_FAULT = 4'h8;
  localparam logic [3:0] OP_DONE  = 4'h9;

  logic                            CLK;
  logic                            resetn;
  move_cmd_t                       host_cmd;
  logic                            host_valid;
  logic                            host_ready;
  logic                            halt;
  logic                            step;
  logic                            dir;
  drive_status_t                   status;
  enc_sample_t                     enc_in;
  logic signed [`MOTION_POS_W-1:0] enc_count;
  logic                            enc_fault;

  logic [63:0] golden [MAX_REC];

  // Reference model of the moves handed to the DUT
  logic exp_dir    [MAX_MOVES];
  int   exp_steps  [MAX_MOVES];
  int   exp_period [MAX_MOVES]; // Already clamped to the minimum
  int   seen       [MAX_MOVES] = '{default: 0};
  int   n_moves    = 0;
  int   cur        = 0;         // Move the next pulse belongs to
  int   last_pulse = 0;
  int   model_pos  = 0;
  int   accept_cyc = 0;
  logic halt_armed = 1'b0;
  int   halt_idx   = 0;
  int   halt_at    = 0;

  int cyc        = 0;
  int limit      = 0;
  int cur_test   = 0;
  int mismatches = 0;
  int failures   = 0;

  motion_core uut (
    .CLK        (CLK),
    .resetn     (resetn),
    .host_cmd   (host_cmd),
    .host_valid (host_valid),
    .host_ready (host_ready),
    .halt       (halt),
    .step       (step),
    .dir        (dir),
    .status     (status),
    .enc_in     (enc_in),
    .enc_count  (enc_count),
    .enc_fault  (enc_fault)
  );

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset";
      2:       return "step_count";
      3:       return "screening";
      4:       return "credits";
      5:       return "halt";
      6:       return "encoder";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string what, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %0d actual %0d", test_name(cur_test), what,
               expected, actual);
      mismatches++;
    end
  endtask

  task automatic close_run();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // Host handshake that returns on the falling edge after the transfer
  task automatic send_move(input logic [63:0] rec);
    move_cmd_t cmd;
    int        gap;
    int        p;

    cmd.dir    = rec[32];
    cmd.steps  = rec[31:16];
    cmd.period = rec[15:0];
    gap = $urandom % 4;
    repeat (gap) @(negedge CLK);
    host_cmd   = cmd;
    host_valid = 1'b1;
    while (!host_ready) begin
      @(negedge CLK);
    end
    accept_cyc <= cyc; // Transfer on the coming rising edge
    if (cmd.steps != '0) begin
      p = (cmd.period < MIN_P) ? MIN_P : cmd.period;
      exp_dir[n_moves]    <= cmd.dir;
      exp_steps[n_moves]  <= cmd.steps;
      exp_period[n_moves] <= p;
      n_moves             <= n_moves + 1;
    end
    @(negedge CLK);
    host_valid = 1'b0;
  endtask

  task automatic wait_idle(input logic [63:0] rec);
    while (!(status.move_done && cur == n_moves)) begin
      @(negedge CLK);
    end
    check_value("position", rec[31:0], status.position);
    check_value("position vs pulses", model_pos, status.position);
  endtask

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cyc <= cyc + 1;
  end

  always @(negedge CLK) begin
    if (limit > 0 && cyc > limit) begin
      $display("ERROR: timeout after %0d cycles in test %s", cyc, test_name(cur_test));
      failures++;
      close_run();
    end
  end

  // Pulse checker that also drives an armed halt
  always @(negedge CLK) begin
    logic stop;

    stop = 1'b0;
    halt = 1'b0;
    if (resetn && step) begin
      if (cur >= n_moves) begin
        $display("ERROR: step pulse at cycle %0d with no move pending", cyc);
        failures++;
      end else begin
        check_value("dir", exp_dir[cur], dir);
        if (seen[cur] > 0) begin
          check_value("step spacing", exp_period[cur], cyc - last_pulse);
        end
        seen[cur]++;
        if (seen[cur] < exp_steps[cur]) begin
          check_value("busy", 1'b1, status.busy); // Move still has pulses to go
        end
        model_pos += exp_dir[cur] ? 1 : -1;
        last_pulse = cyc;
        if (halt_armed && cur == halt_idx && seen[cur] == halt_at) begin
          stop = 1'b1;
          halt = 1'b1; // Lands before the next pulse is due
          halt_armed <= 1'b0;
        end
        if (stop || seen[cur] == exp_steps[cur]) begin
          cur++;
        end
      end
    end
    if (resetn && status.move_done && cur < n_moves && cyc > accept_cyc + 2) begin
      $display("ERROR: move_done high at cycle %0d while moves remain", cyc);
      failures++;
    end
  end

  initial begin
    logic [63:0] rec;
    int          i;
    int          steps_sum;
    int          max_p;

    void'($urandom(32'h3672_8b57));
    resetn     = 1'b0;
    host_cmd   = '0;
    host_valid = 1'b0;
    halt       = 1'b0;
    enc_in     = '0;

    $readmemh("bench/motion_golden.txt", golden);
    if (^golden[0] === 1'bx) begin
      $display("ERROR: golden file missing or unreadable");
      failures++;
    end

    // Worst case run time from the moves in the file
    steps_sum = 0;
    max_p     = MIN_P;
    for (i = 0; i < MAX_REC; i++) begin
      if (golden[i][63:60] == OP_MOVE) begin
        steps_sum += golden[i][31:16];
        if (golden[i][15:0] > max_p) begin
          max_p = golden[i][15:0];
        end
      end
    end
    limit = steps_sum * max_p + 200;

    repeat (2) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b1;

    cur_test = 1;
    check_value("busy", 1'b0, status.busy);
    check_value("position", 0, status.position);

    i = 0;
    while (i < MAX_REC && golden[i][63:60] != OP_END) begin
      rec      = golden[i];
      cur_test = rec[59:56];
      case (rec[63:60])
        OP_MOVE: send_move(rec);
        OP_HALT: begin
          halt_idx   <= n_moves - 1; // Last move pushed
          halt_at    <= rec[15:0];
          halt_armed <= 1'b1;
        end
        OP_IDLE: wait_idle(rec);
        OP_BUSY: begin
          while (!status.busy) begin
            @(negedge CLK);
          end
        end
        OP_READY: check_value("host_ready", rec[0], host_ready);
        OP_ENC: begin
          enc_in = rec[1:0];
          @(negedge CLK);
        end
        OP_COUNT: check_value("enc_count", rec[31:0], enc_count);
        OP_FAULT: check_value("enc_fault", rec[0], enc_fault);
        OP_DONE:  check_value("move_done", rec[0], status.move_done);
        default: begin
          $display("ERROR: unknown golden record %h at line %0d", rec, i);
          failures++;
        end
      endcase
      i++;
    end
    close_run();
  end

endmodule

`default_nettype wire

/* bench/motion_golden.txt */
// Columns: op, test, padding, dir, steps, period (checks keep their value in the low 32 bits)
// op 1 move, 2 halt after n pulses, 3 wait idle + position, 4 wait busy, 5 ready, 6 enc, 7 count, 8 fault, 9 done
91_00000_0_0000_0001
51_00000_0_0000_0001
71_00000_0_0000_0000
81_00000_0_0000_0000
12_00000_1_0005_0006
12_00000_0_0002_0005
12_00000_1_0003_0008
32_00000_0_0000_0006
13_00000_1_0000_0009
53_00000_0_0000_0001
13_00000_0_0003_0001
33_00000_0_0000_0003
14_00000_1_0003_0028
44_00000_0_0000_0000
14_00000_1_0001_0004
14_00000_0_0002_0005
14_00000_1_0001_0004
14_00000_0_0001_0006
54_00000_0_0000_0000
14_00000_1_0002_0004
34_00000_0_0000_0007
15_00000_1_0006_000a
25_00000_0_0000_0002
15_00000_0_0004_0005
35_00000_0_0000_0005
66_00000_0_0000_0002
66_00000_0_0000_0003
66_00000_0_0000_0001
66_00000_0_0000_0000
76_00000_0_0000_0004
66_00000_0_0000_0001
66_00000_0_0000_0003
76_00000_0_0000_0002
86_00000_0_0000_0000
66_00000_0_0000_0000
86_00000_0_0000_0001
76_00000_0_0000_0002
00_00000_0_0000_0000

/* hdl/drive_pkg.sv */
`default_nettype none

`include "motion_params.svh"

package drive_pkg;

  // Encoder phases, a in the upper bit
  typedef struct packed {
    logic a;
    logic b;
  } enc_sample_t;

  typedef struct packed {
    logic signed [`MOTION_POS_W-1:0] position;
    logic                            busy;      // Move in progress
    logic                            move_done; // Idle with nothing queued
  } drive_status_t;

endpackage

`default_nettype wire

/* hdl/motion_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module motion_core import motion_pkg::*; import drive_pkg::*; (
  input  wire            CLK,
  input  wire            resetn,
  input  wire move_cmd_t host_cmd,
  input  wire            host_valid,
  output logic           host_ready,
  input  wire            halt,
  output logic           step,
  output logic           dir,
  output drive_status_t  status,
  input  wire enc_sample_t enc_in,
  output logic signed [`MOTION_POS_W-1:0] enc_count,
  output logic           enc_fault
);

  move_push_t push;
  move_cmd_t  buf_head;
  logic       buf_empty;
  logic       buf_pop;
  logic       credit_return;

  move_intake intake (
    .CLK           (CLK),
    .resetn        (resetn),
    .host_cmd      (host_cmd),
    .host_valid    (host_valid),
    .host_ready    (host_ready),
    .credit_return (credit_return),
    .push          (push)
  );

  move_buffer queue (
    .CLK           (CLK),
    .resetn        (resetn),
    .push          (push),
    .buf_pop       (buf_pop),
    .buf_head      (buf_head),
    .buf_empty     (buf_empty),
    .credit_return (credit_return)
  );

  step_sequencer sequencer (
    .CLK       (CLK),
    .resetn    (resetn),
    .buf_head  (buf_head),
    .buf_empty (buf_empty),
    .buf_pop   (buf_pop),
    .halt      (halt),
    .step      (step),
    .dir       (dir),
    .status    (status)
  );

  // Encoder side runs on its own, no link to the step path
  quad_decoder encoder (
    .CLK       (CLK),
    .resetn    (resetn),
    .enc_in    (enc_in),
    .enc_count (enc_count),
    .enc_fault (enc_fault)
  );

endmodule

`default_nettype wire

/* hdl/motion_params.svh */
`ifndef MOTION_PARAMS_SVH
`define MOTION_PARAMS_SVH

// Queue depth, also the credit count the intake starts with
`define MOTION_BUF_DEPTH 4

// Command field widths
`define MOTION_STEP_W 16
`define MOTION_PERIOD_W 16 // Step period in CLK cycles

// Shortest step period the sequencer is given
`define MOTION_MIN_PERIOD 4

// Step position and encoder count
`define MOTION_POS_W 32

`endif

/* hdl/motion_pkg.sv */
`default_nettype none

`include "motion_params.svh"

package motion_pkg;

  // One move as the host hands it over
  typedef struct packed {
    logic                        dir;    // 1 counts up
    logic [`MOTION_STEP_W-1:0]   steps;
    logic [`MOTION_PERIOD_W-1:0] period; // Cycles between step pulses
  } move_cmd_t;

  // Intake to buffer write
  typedef struct packed {
    logic      valid;
    move_cmd_t cmd;
  } move_push_t;

endpackage

`default_nettype wire

/* hdl/move_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module move_buffer import motion_pkg::*; (
  input  wire        CLK,
  input  wire        resetn,
  input  wire move_push_t push,
  input  wire        buf_pop,
  output move_cmd_t  buf_head,
  output logic       buf_empty,
  output logic       credit_return
);

  localparam int DEPTH = `MOTION_BUF_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

  move_cmd_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // Entries held
  logic             do_push;
  logic             do_pop;

  assign do_push = push.valid;  // Room is guaranteed by the intake credits
  assign do_pop  = buf_pop && !buf_empty;

  assign buf_head      = mem[rd_ptr];
  assign buf_empty     = (count == '0);
  assign credit_return = do_pop;     // Freed slot goes straight back as a credit

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push.cmd;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  no_overflow: assert property (@(posedge CLK) disable iff (!resetn)
    push.valid |-> (count != FULL))
    else $error("move_buffer: push into a full buffer");

  no_underflow: assert property (@(posedge CLK) disable iff (!resetn)
    buf_pop |-> !buf_empty)
    else $error("move_buffer: pop from an empty buffer");

endmodule

`default_nettype wire

/* hdl/move_intake.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module move_intake import motion_pkg::*; (
  input  wire        CLK,
  input  wire        resetn,
  input  wire move_cmd_t host_cmd,
  input  wire        host_valid,
  output logic       host_ready,
  input  wire        credit_return,
  output move_push_t push
);

  localparam int CRED_W = $clog2(`MOTION_BUF_DEPTH + 1);
  localparam logic [CRED_W-1:0] FULL_CREDITS = `MOTION_BUF_DEPTH;
  localparam logic [`MOTION_PERIOD_W-1:0] MIN_PERIOD = `MOTION_MIN_PERIOD;

  logic [CRED_W-1:0] credits;
  logic              accept;
  logic              spend;      // Accepted and worth queuing
  move_cmd_t         screened;
  logic              push_valid;
  move_cmd_t         push_cmd;

  assign host_ready = (credits != '0);
  assign accept     = host_valid && host_ready;
  assign spend      = accept && (host_cmd.steps != '0); // Zero-step moves vanish here

  // Clamp the period so the sequencer never sees a too-fast move
  always_comb begin
    screened = host_cmd;
    if (host_cmd.period < MIN_PERIOD) begin
      screened.period = MIN_PERIOD;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      credits    <= FULL_CREDITS;
      push_valid <= 1'b0;
    end else begin
      push_valid <= spend;
      case ({spend, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // Spend and return cancel out
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (spend) begin
      push_cmd <= screened;
    end
  end

  assign push = '{valid: push_valid, cmd: push_cmd};

  // Buffer must never hand back more credits than it owns
  credit_bound: assert property (@(posedge CLK) disable iff (!resetn)
    credits <= FULL_CREDITS)
    else $error("move_intake: credit count above buffer depth");

endmodule

`default_nettype wire

/* hdl/quad_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module quad_decoder import drive_pkg::*; (
  input  wire         CLK,
  input  wire         resetn,
  input  wire enc_sample_t enc_in,
  output logic signed [`MOTION_POS_W-1:0] enc_count,
  output logic        enc_fault
);

  enc_sample_t last;        // Phases seen one cycle ago
  logic [1:0]  moved;
  logic        count_up;
  logic        count_down;

  assign moved = {last.a ^ enc_in.a, last.b ^ enc_in.b};

  // Gray sequence 00 10 11 01 counts up, A leading B
  always_comb begin
    count_up   = 1'b0;
    count_down = 1'b0;
    case ({last, enc_in})
      4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: count_up   = 1'b1;
      4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: count_down = 1'b1;
      default: ;  // No change or a fault
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enc_count <= '0;
      enc_fault <= 1'b0;
    end else begin
      if (count_up) begin
        enc_count <= enc_count + 1;
      end else if (count_down) begin
        enc_count <= enc_count - 1;
      end
      if (moved == 2'b11) begin
        enc_fault <= 1'b1; // Sticky until reset
      end
    end
  end

  always_ff @(posedge CLK) begin
    last <= enc_in;
  end

endmodule

`default_nettype wire

/* hdl/step_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module step_sequencer import motion_pkg::*; import drive_pkg::*; (
  input  wire           CLK,
  input  wire           resetn,
  input  wire move_cmd_t buf_head,
  input  wire           buf_empty,
  output logic          buf_pop,
  input  wire           halt,
  output logic          step,
  output logic          dir,
  output drive_status_t status
);

  logic                            busy;
  logic [`MOTION_PERIOD_W-1:0]     period_q;  // Reload value for the timer
  logic [`MOTION_PERIOD_W-1:0]     timer;
  logic [`MOTION_STEP_W-1:0]       remaining;
  logic signed [`MOTION_POS_W-1:0] position;
  logic                            fire;      // Step pulse due next cycle

  // Only take a new move once the current one is over
  assign buf_pop = !busy && !buf_empty;
  assign fire    = busy && !halt && (timer == 1'b1);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy      <= 1'b0;
      step      <= 1'b0;
      dir       <= 1'b0;
      timer     <= '0;
      remaining <= '0;
      position  <= '0;
    end else begin
      step <= fire;
      if (buf_pop) begin
        busy      <= 1'b1;
        dir       <= buf_head.dir;
        timer     <= buf_head.period;
        remaining <= buf_head.steps;
      end else if (busy) begin
        if (halt) begin
          busy <= 1'b0; // Abort, no further pulses
        end else if (fire) begin
          timer     <= period_q;
          remaining <= remaining - 1'b1;
          position  <= dir ? position + 1 : position - 1;
          if (remaining == 1'b1) begin
            busy <= 1'b0; // Last pulse of the move
          end
        end else begin
          timer <= timer - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (buf_pop) begin
      period_q <= buf_head.period;
    end
  end

  assign status = '{position: position, busy: busy, move_done: !busy && buf_empty};

  // Intake drops empty moves, so every popped entry has work in it
  popped_nonzero: assert property (@(posedge CLK) disable iff (!resetn)
    buf_pop |-> (buf_head.steps != '0))
    else $error("step_sequencer: popped a move with zero steps");

  // Pulses stay at least the clamped minimum period apart, across moves too
  pulse_spacing: assert property (@(posedge CLK) disable iff (!resetn)
    step |=> !step [*(`MOTION_MIN_PERIOD - 1)])
    else $error("step_sequencer: step pulses closer than the minimum period");

endmodule

`default_nettype wire

/* motion_core.f */
+incdir+hdl
hdl/motion_pkg.sv
hdl/drive_pkg.sv
hdl/move_intake.sv
hdl/move_buffer.sv
hdl/step_sequencer.sv
hdl/quad_decoder.sv
hdl/motion_core.sv
bench/motion_core_tb.sv
